// File: flist.f
+incdir+hw
hw/datapathPkg.sv
hw/selectAndEncode.sv
hw/registerFile.sv
hw/busInterface.sv
hw/datapathTop.sv
verification/tbDatapath.sv

// File: Makefile
TOP = tbDatapath

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// File: verification/tbDatapath.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module tbDatapath;
    import datapathPkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int RANDOM_OPS      = 1000;
    // reset plus all directed tests fit well inside this budget
    localparam int DIRECTED_CYCLES = 500;
    localparam int MAX_CYCLES      = 2 * (DIRECTED_CYCLES + RANDOM_OPS);
    localparam word_t C_MASK       = (word_t'(1) << `DP_C_WIDTH) - 1;

    logic    clk;
    logic    rstN;
    dpCtrl_t ctrl;
    word_t   extIn;
    word_t   bus;
    word_t   outPort;

    // reference state, tracks the register file, IR and output port
    word_t   modelRegs [`DP_NUM_REGS];
    word_t   modelIr;
    word_t   modelOutPort;
    word_t   modelNext;
    regIdx_t modelIdx;

    int     modelErrors = 0;
    int     directedErrors = 0;
    int     cycleCount = 0;
    integer seed;
    word_t  vals [`DP_NUM_REGS];

    datapathTop DUT (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .extIn   (extIn),
        .bus     (bus),
        .outPort (outPort)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // register number named by the strobed instruction fields
    function automatic regIdx_t modelIndex(input dpCtrl_t c);
        regIdx_t idx;
        idx = '0;
        if (c.gra) idx = idx | modelIr[`DP_RA_LSB +: `DP_FIELD_WIDTH];
        if (c.grb) idx = idx | modelIr[`DP_RB_LSB +: `DP_FIELD_WIDTH];
        if (c.grc) idx = idx | modelIr[`DP_RC_LSB +: `DP_FIELD_WIDTH];
        return idx;
    endfunction

    // expected bus value for one control word
    function automatic word_t modelBus(input dpCtrl_t c, input word_t ext);
        regIdx_t idx;
        word_t   result;
        idx = modelIndex(c);
        result = '0;
        if (c.rout || c.baout) begin
            // r0 as a base address stands for address zero
            if (!(c.baout && idx == '0)) begin
                result = modelRegs[idx];
            end
        end else if (c.cOut) begin
            result = modelIr & C_MASK;
            if (modelIr[`DP_C_WIDTH-1]) begin
                result = result | ~C_MASK;
            end
        end else if (c.extOut) begin
            result = ext;
        end
        return result;
    endfunction

    task automatic checkValue(input string what, input word_t got, input word_t expected,
                              inout int errors);
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // compare mid-cycle, then step the model to what the coming edge loads
    always @(negedge clk) begin
        if (rstN !== 1'b1) begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                modelRegs[i] = '0;
            end
            modelIr      = '0;
            modelOutPort = '0;
        end else begin
            modelNext = modelBus(ctrl, extIn);
            modelIdx  = modelIndex(ctrl);
            checkValue("bus", bus, modelNext, modelErrors);
            checkValue("outPort", outPort, modelOutPort, modelErrors);
            if (ctrl.rin) modelRegs[modelIdx] = modelNext;
            if (ctrl.irIn) modelIr = modelNext;
            if (ctrl.outPortIn) modelOutPort = modelNext;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic dpCtrl_t fieldCtrl(input int field);
        dpCtrl_t c;
        c = '0;
        case (field)
            0: c.gra = 1'b1;
            1: c.grb = 1'b1;
            default: c.grc = 1'b1;
        endcase
        return c;
    endfunction

    function automatic word_t makeInstr(input int ra, input int rb, input int rc);
        word_t instr;
        instr = '0;
        instr[`DP_RA_LSB +: `DP_FIELD_WIDTH] = regIdx_t'(ra);
        instr[`DP_RB_LSB +: `DP_FIELD_WIDTH] = regIdx_t'(rb);
        instr[`DP_RC_LSB +: `DP_FIELD_WIDTH] = regIdx_t'(rc);
        return instr;
    endfunction

    // one control word, held for one clock
    task automatic applyCycle(input dpCtrl_t c, input word_t ext);
        @(posedge clk);
        ctrl  <= c;
        extIn <= ext;
    endtask

    task automatic loadIr(input word_t value);
        dpCtrl_t c;
        c = '0;
        c.extOut = 1'b1;
        c.irIn = 1'b1;
        applyCycle(c, value);
    endtask

    task automatic writeReg(input int field, input word_t value);
        dpCtrl_t c;
        c = fieldCtrl(field);
        c.rin = 1'b1;
        c.extOut = 1'b1;
        applyCycle(c, value);
    endtask

    task automatic readToPort(input dpCtrl_t c, input word_t expected, input string what);
        dpCtrl_t portCtrl;
        portCtrl = c;
        portCtrl.outPortIn = 1'b1;
        applyCycle(portCtrl, '0);
        // port is loaded by the next edge
        applyCycle('0, '0);
        @(negedge clk);
        checkValue(what, outPort, expected, directedErrors);
    endtask

    task automatic readField(input int field, input logic baseMode, input word_t expected,
                             input string what);
        dpCtrl_t c;
        c = fieldCtrl(field);
        c.baout = baseMode;
        c.rout = ~baseMode;
        readToPort(c, expected, what);
    endtask

    task automatic checkConstant(input word_t instr);
        dpCtrl_t c;
        word_t   expected;
        c = '0;
        c.cOut = 1'b1;
        expected = instr[18] ? (instr | 32'hFFF8_0000) : (instr & 32'h0007_FFFF);
        loadIr(instr);
        readToPort(c, expected, $sformatf("constant from %h", instr));
    endtask

    initial begin
        dpCtrl_t c;
        word_t   r;
        rstN  <= 1'b0;
        ctrl  <= '0;
        extIn <= '0;
        seed  = 32'he060;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        checkValue("bus after reset", bus, '0, directedErrors);
        checkValue("outPort after reset", outPort, '0, directedErrors);
        for (int n = 0; n < `DP_NUM_REGS; n++) begin
            loadIr(makeInstr(n, 0, 0));
            readField(0, 1'b0, '0, $sformatf("r%0d after reset", n));
        end

        // low nibble keeps every value distinct
        for (int n = 0; n < `DP_NUM_REGS; n++) begin
            vals[n] = ($random(seed) & 32'hFFFF_FFF0) | n;
            loadIr(makeInstr(n, 0, 0));
            writeReg(0, vals[n]);
        end
        for (int n = 0; n < `DP_NUM_REGS; n++) begin
            loadIr(makeInstr(0, n, 0));
            readField(1, 1'b0, vals[n], $sformatf("r%0d readback", n));
        end

        loadIr(makeInstr(0, 0, 0));
        readField(0, 1'b1, '0, "r0 via baout");
        readField(0, 1'b0, vals[0], "r0 via rout");
        loadIr(makeInstr(5, 0, 0));
        readField(0, 1'b1, vals[5], "r5 via baout");
        readField(0, 1'b0, vals[5], "r5 via rout");

        checkConstant(32'h0004_0001);
        checkConstant(32'h0003_FFFF);
        checkConstant(32'hFFFC_1234);
        checkConstant(32'h1238_5678);

        loadIr(makeInstr(3, 7, 12));
        readField(0, 1'b0, vals[3], "Ra field select");
        readField(1, 1'b0, vals[7], "Rb field select");
        readField(2, 1'b0, vals[12], "Rc field select");

        // random words with at most one bus source
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = $random(seed);
            c = dpCtrl_t'(r[11:0]);
            c.rout = 1'b0;
            c.baout = 1'b0;
            c.cOut = 1'b0;
            c.extOut = 1'b0;
            case (r[13:12])
                2'd1: begin
                    c.rout = r[14];
                    c.baout = ~r[14] | r[15];
                end
                2'd2: c.cOut = 1'b1;
                2'd3: c.extOut = 1'b1;
                default: ;
            endcase
            applyCycle(c, $random(seed));
        end
        applyCycle('0, '0);
        applyCycle('0, '0);

        $display("errors: %0d against the model, %0d in directed checks",
                 modelErrors, directedErrors);
        if (modelErrors == 0 && directedErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: hw/datapathTop.sv
`timescale 1ns/1ps

module datapathTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  datapathPkg::dpCtrl_t ctrl,
    input  datapathPkg::word_t   extIn,
    output datapathPkg::word_t   bus,
    output datapathPkg::word_t   outPort
);
    import datapathPkg::*;

    word_t   irOut;
    word_t   cSignExt;
    word_t   regData;
    regSel_t regIn;
    regSel_t regOut;
    logic    baMode;

    // instruction fields to register lines and immediate
    selectAndEncode uSelect (
        .ctrl     (ctrl),
        .irOut    (irOut),
        .regIn    (regIn),
        .regOut   (regOut),
        .baMode   (baMode),
        .cSignExt (cSignExt)
    );

    registerFile uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .regIn   (regIn),
        .regOut  (regOut),
        .baMode  (baMode),
        .bus     (bus),
        .regData (regData)
    );

    // bus mux plus IR and output port
    busInterface uBus (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .regOut   (regOut),
        .regData  (regData),
        .cSignExt (cSignExt),
        .extIn    (extIn),
        .bus      (bus),
        .irOut    (irOut),
        .outPort  (outPort)
    );

endmodule

// File: hw/busInterface.sv
`timescale 1ns/1ps

module busInterface (
    input  logic                 clk,
    input  logic                 rstN,
    input  datapathPkg::dpCtrl_t ctrl,
    input  datapathPkg::regSel_t regOut,
    input  datapathPkg::word_t   regData,
    input  datapathPkg::word_t   cSignExt,
    input  datapathPkg::word_t   extIn,
    output datapathPkg::word_t   bus,
    output datapathPkg::word_t   irOut,
    output datapathPkg::word_t   outPort
);
    import datapathPkg::*;

    logic regDrive;

    // any register drive line claims the bus
    assign regDrive = |regOut;

    // bus source mux
    // sources are exclusive so the order here does not matter
    always_comb begin
        if (regDrive) begin
            bus = regData;
        end else if (ctrl.cOut) begin
            bus = cSignExt;
        end else if (ctrl.extOut) begin
            bus = extIn;
        end else begin
            bus = '0;
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            irOut <= '0;
        end else if (ctrl.irIn) begin
            irOut <= bus;
        end
    end

    // output port register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outPort <= '0;
        end else if (ctrl.outPortIn) begin
            outPort <= bus;
        end
    end

    // one bus driver per cycle across the register file, C and the external input
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({regDrive, ctrl.cOut, ctrl.extOut}))
        else $error("busInterface: more than one bus source active");

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module registerFile (
    input  logic                 clk,
    input  logic                 rstN,
    input  datapathPkg::regSel_t regIn,
    input  datapathPkg::regSel_t regOut,
    input  logic                 baMode,
    input  datapathPkg::word_t   bus,
    output datapathPkg::word_t   regData
);
    import datapathPkg::*;

    word_t   regs [`DP_NUM_REGS];
    regSel_t readSel;

    // general registers, loaded from the bus by their one-hot enable
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // r0 reads as zero when used as a base address
    always_comb begin
        readSel    = regOut;
        readSel[0] = regOut[0] & ~baMode;
    end

    // one-hot AND-OR read, zero when nothing is selected
    always_comb begin
        regData = '0;
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            regData = regData | (regs[i] & {`DP_WORD_WIDTH{readSel[i]}});
        end
    end

endmodule

// File: hw/selectAndEncode.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module selectAndEncode (
    input  datapathPkg::dpCtrl_t ctrl,
    input  datapathPkg::word_t   irOut,
    output datapathPkg::regSel_t regIn,
    output datapathPkg::regSel_t regOut,
    output logic                 baMode,
    output datapathPkg::word_t   cSignExt
);
    import datapathPkg::*;

    regIdx_t raField;
    regIdx_t rbField;
    regIdx_t rcField;
    regIdx_t regIdx;
    regSel_t decoded;
    logic    readStrobe;

    // register fields of the current instruction
    assign raField = irOut[`DP_RA_LSB +: `DP_FIELD_WIDTH];
    assign rbField = irOut[`DP_RB_LSB +: `DP_FIELD_WIDTH];
    assign rcField = irOut[`DP_RC_LSB +: `DP_FIELD_WIDTH];

    // each field passes only when its strobe is high
    // with no strobe the index falls back to register 0
    assign regIdx = ({`DP_FIELD_WIDTH{ctrl.gra}} & raField)
                  | ({`DP_FIELD_WIDTH{ctrl.grb}} & rbField)
                  | ({`DP_FIELD_WIDTH{ctrl.grc}} & rcField);

    // 4 to 16 decoder
    always_comb begin
        decoded = '0;
        decoded[regIdx] = 1'b1;
    end

    // base-address reads use the same drive line as plain reads
    assign readStrobe = ctrl.rout | ctrl.baout;

    assign regIn  = decoded & {`DP_NUM_REGS{ctrl.rin}};
    assign regOut = decoded & {`DP_NUM_REGS{readStrobe}};

    // register file needs to know when r0 must read as zero
    assign baMode = ctrl.baout;

    // immediate C sign-extended from its top bit
    assign cSignExt = {
        {(`DP_WORD_WIDTH - `DP_C_WIDTH){irOut[`DP_C_WIDTH-1]}},
        irOut[`DP_C_WIDTH-1:0]
    };

endmodule

// File: hw/datapathPkg.sv
`include "datapath_params.svh"

package datapathPkg;

    // bus, register and instruction values
    typedef logic [`DP_WORD_WIDTH-1:0] word_t;

    // register number as found in an Ra, Rb or Rc field
    typedef logic [`DP_FIELD_WIDTH-1:0] regIdx_t;

    // one-hot register line, bit n is register n
    typedef logic [`DP_NUM_REGS-1:0] regSel_t;

    // control strobes applied each cycle
    // spare bits sit at the top and are ignored by the core
    typedef struct packed {
        logic [1:0] spare;
        // which instruction field names the register
        logic       gra;
        logic       grb;
        logic       grc;
        // register file direction
        logic       rin;
        logic       rout;
        logic       baout;
        // other bus sources
        logic       cOut;
        logic       extOut;
        // bus sinks
        logic       irIn;
        logic       outPortIn;
    } dpCtrl_t;

endpackage

// File: hw/datapath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// word and register file sizes
`define DP_WORD_WIDTH 32
`define DP_NUM_REGS 16

// register fields of the instruction word, each one register index wide
`define DP_FIELD_WIDTH 4
`define DP_RA_LSB 23
`define DP_RB_LSB 19
`define DP_RC_LSB 15

// immediate field in the low bits, sign bit is its top bit
`define DP_C_WIDTH 19

`endif
